// ==== design/rv32i_wb_cfg.svh ====
`ifndef RV32I_WB_CFG_SVH
`define RV32I_WB_CFG_SVH

// Width of every data path in the write-back end, fixed by RV32I
`define WB_XLEN 32

// Register address width for the 32-entry integer register file
`define WB_REG_AW 5

// Retire counter width, wide enough that it never wraps in practice
`define WB_ORDER_W 64

`endif

// ==== design/rv32i_types.sv ====
package rv32i_types;

    // Which candidate value is written back to the destination register
    typedef enum logic [3:0] {
        alu_out_wb  = 4'd0,
        br_en_wb    = 4'd1,
        u_imm_wb    = 4'd2,
        load_wb     = 4'd3,
        pc_plus4_wb = 4'd4
    } wb_sel_t;

    // Load width and extension, decoded from funct3 earlier in the pipe
    typedef enum logic [2:0] {
        lb_mem  = 3'd0,
        lbu_mem = 3'd1,
        lh_mem  = 3'd2,
        lhu_mem = 3'd3,
        lw_mem  = 3'd4
    } load_op_t;

endpackage

// ==== design/wb_stage_reg.sv ====
`include "rv32i_wb_cfg.svh"

module wb_stage_reg (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic [`WB_XLEN-1:0]    in_pc,
    input  logic [`WB_REG_AW-1:0]  in_rd_s,
    input  logic                   in_regf_we,
    input  logic                   in_mem_read,
    input  logic                   in_mem_write,
    input  rv32i_types::load_op_t  in_load_op,
    input  rv32i_types::wb_sel_t   in_wb_sel,
    input  logic [`WB_XLEN-1:0]    in_alu_out,
    input  logic                   in_br_en,
    input  logic [`WB_XLEN-1:0]    in_u_imm,
    input  logic [`WB_XLEN-1:0]    in_mem_addr,
    input  logic                   dmem_resp,
    output logic                   stall,
    output logic                   done,
    output logic [`WB_XLEN-1:0]    wb_pc,
    output logic [`WB_REG_AW-1:0]  wb_rd_s,
    output logic                   wb_regf_we,
    output logic                   wb_mem_write,
    output rv32i_types::load_op_t  wb_load_op,
    output rv32i_types::wb_sel_t   wb_wb_sel,
    output logic [`WB_XLEN-1:0]    wb_alu_out,
    output logic                   wb_br_en,
    output logic [`WB_XLEN-1:0]    wb_u_imm,
    output logic [`WB_XLEN-1:0]    wb_mem_addr
);
    import rv32i_types::*;

    logic wb_valid;
    logic wb_mem_read;

    // A held load blocks the stage until the memory answers
    assign stall = wb_valid & wb_mem_read & ~dmem_resp;
    assign done  = wb_valid & ~stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else if (!stall) begin
            wb_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && !stall) begin
            wb_pc        <= in_pc;
            wb_rd_s      <= in_rd_s;
            wb_regf_we   <= in_regf_we;
            wb_mem_read  <= in_mem_read;
            wb_mem_write <= in_mem_write;
            wb_load_op   <= in_load_op;
            wb_wb_sel    <= in_wb_sel;
            wb_alu_out   <= in_alu_out;
            wb_br_en     <= in_br_en;
            wb_u_imm     <= in_u_imm;
            wb_mem_addr  <= in_mem_addr;
        end
    end

    // An instruction blocked by a stall has to stay on the inputs unchanged
    upstream_held_during_stall: assert property (@(posedge clk) disable iff (reset)
        stall && in_valid |=> in_valid && $stable(in_pc) && $stable(in_rd_s)
                              && $stable(in_load_op) && $stable(in_wb_sel)
                              && $stable(in_mem_addr) && $stable(in_regf_we))
        else $error("upstream changed a blocked instruction while stalled");

endmodule

// ==== design/load_align.sv ====
`include "rv32i_wb_cfg.svh"

module load_align (
    input  rv32i_types::load_op_t  wb_load_op,
    input  logic [`WB_XLEN-1:0]    wb_mem_addr,
    input  logic [`WB_XLEN-1:0]    dmem_rdata,
    output logic [`WB_XLEN-1:0]    load_v
);
    import rv32i_types::*;

    logic [1:0]  offset;
    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // Memory returns the whole aligned word, the offset picks the lane
    assign offset    = wb_mem_addr[1:0];
    assign byte_lane = dmem_rdata[8 * offset +: 8];
    assign half_lane = dmem_rdata[16 * offset[1] +: 16];

    always_comb begin
        case (wb_load_op)
            lb_mem: begin
                load_v = {{(`WB_XLEN-8){byte_lane[7]}}, byte_lane};
            end
            lbu_mem: begin
                load_v = {{(`WB_XLEN-8){1'b0}}, byte_lane};
            end
            lh_mem: begin
                load_v = {{(`WB_XLEN-16){half_lane[15]}}, half_lane};
            end
            lhu_mem: begin
                load_v = {{(`WB_XLEN-16){1'b0}}, half_lane};
            end
            default: begin
                load_v = dmem_rdata;
            end
        endcase
    end

    // Misaligned halfwords are trapped upstream and never reach this stage
    always_comb begin
        if (wb_load_op == lh_mem || wb_load_op == lhu_mem) begin
            halfword_aligned: assert final (!offset[0])
                else $error("halfword load at odd address");
        end
    end

endmodule

// ==== design/result_select.sv ====
`include "rv32i_wb_cfg.svh"

module result_select (
    input  rv32i_types::wb_sel_t   wb_wb_sel,
    input  logic [`WB_XLEN-1:0]    wb_pc,
    input  logic [`WB_XLEN-1:0]    wb_alu_out,
    input  logic                   wb_br_en,
    input  logic [`WB_XLEN-1:0]    wb_u_imm,
    output logic [`WB_XLEN-1:0]    sel_v
);
    import rv32i_types::*;

    logic [`WB_XLEN-1:0] pc_plus4;

    // Link address for jal and jalr
    assign pc_plus4 = wb_pc + `WB_XLEN'd4;

    always_comb begin
        case (wb_wb_sel)
            alu_out_wb: begin
                sel_v = wb_alu_out;
            end
            br_en_wb: begin
                sel_v = {{(`WB_XLEN-1){1'b0}}, wb_br_en};
            end
            u_imm_wb: begin
                sel_v = wb_u_imm;
            end
            pc_plus4_wb: begin
                sel_v = pc_plus4;
            end
            // load_wb is served by the load aligner
            default: begin
                sel_v = '0;
            end
        endcase
    end

endmodule

// ==== design/wb_commit.sv ====
`include "rv32i_wb_cfg.svh"

module wb_commit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   done,
    input  rv32i_types::wb_sel_t   wb_wb_sel,
    input  logic [`WB_REG_AW-1:0]  wb_rd_s,
    input  logic                   wb_regf_we,
    input  logic                   wb_mem_write,
    input  logic [`WB_XLEN-1:0]    load_v,
    input  logic [`WB_XLEN-1:0]    sel_v,
    output logic                   regf_we,
    output logic [`WB_REG_AW-1:0]  regf_rd_s,
    output logic [`WB_XLEN-1:0]    regf_rd_v,
    output logic [`WB_ORDER_W-1:0] retire_count
);
    import rv32i_types::*;

    assign regf_rd_v = (wb_wb_sel == load_wb) ? load_v : sel_v;

    // Stores carry a garbage rd field, so they are steered to x0
    assign regf_rd_s = wb_mem_write ? '0 : wb_rd_s;

    assign regf_we = done & wb_regf_we & ~wb_mem_write & (regf_rd_s != '0);

    // Every retiring instruction is counted, even one that writes nothing
    always_ff @(posedge clk) begin
        if (reset) begin
            retire_count <= '0;
        end else if (done) begin
            retire_count <= retire_count + 1'b1;
        end
    end

    // Only the five defined selects may reach the register file
    legal_select_on_retire: assert property (@(posedge clk) disable iff (reset)
        done |-> wb_wb_sel inside {alu_out_wb, br_en_wb, u_imm_wb, load_wb, pc_plus4_wb})
        else $error("retiring instruction carries an undefined write-back select");

endmodule

// ==== design/regfile.sv ====
`include "rv32i_wb_cfg.svh"

module regfile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   regf_we,
    input  logic [`WB_REG_AW-1:0]  regf_rd_s,
    input  logic [`WB_XLEN-1:0]    regf_rd_v,
    input  logic [`WB_REG_AW-1:0]  rs_s,
    output logic [`WB_XLEN-1:0]    rs_v
);

    localparam int NUM_REGS = 1 << `WB_REG_AW;

    // Entry 0 exists only to keep indexing simple and is never written
    logic [`WB_XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (regf_we && regf_rd_s != '0) begin
            regs[regf_rd_s] <= regf_rd_v;
        end
    end

    // Decode reads here, so a write is visible right after its edge
    always_comb begin
        if (rs_s == '0) begin
            rs_v = '0;
        end else begin
            rs_v = regs[rs_s];
        end
    end

endmodule

// ==== design/wb_subsystem.sv ====
`include "rv32i_wb_cfg.svh"

module wb_subsystem (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  logic [`WB_XLEN-1:0]    in_pc,
    input  logic [`WB_REG_AW-1:0]  in_rd_s,
    input  logic                   in_regf_we,
    input  logic                   in_mem_read,
    input  logic                   in_mem_write,
    input  rv32i_types::load_op_t  in_load_op,
    input  rv32i_types::wb_sel_t   in_wb_sel,
    input  logic [`WB_XLEN-1:0]    in_alu_out,
    input  logic                   in_br_en,
    input  logic [`WB_XLEN-1:0]    in_u_imm,
    input  logic [`WB_XLEN-1:0]    in_mem_addr,
    input  logic                   dmem_resp,
    input  logic [`WB_XLEN-1:0]    dmem_rdata,
    output logic                   stall,
    input  logic [`WB_REG_AW-1:0]  rs_s,
    output logic [`WB_XLEN-1:0]    rs_v,
    output logic [`WB_ORDER_W-1:0] retire_count
);
    import rv32i_types::*;

    logic                  done;
    logic [`WB_XLEN-1:0]   wb_pc;
    logic [`WB_REG_AW-1:0] wb_rd_s;
    logic                  wb_regf_we;
    logic                  wb_mem_write;
    load_op_t              wb_load_op;
    wb_sel_t               wb_wb_sel;
    logic [`WB_XLEN-1:0]   wb_alu_out;
    logic                  wb_br_en;
    logic [`WB_XLEN-1:0]   wb_u_imm;
    logic [`WB_XLEN-1:0]   wb_mem_addr;
    logic [`WB_XLEN-1:0]   load_v;
    logic [`WB_XLEN-1:0]   sel_v;
    logic                  regf_we;
    logic [`WB_REG_AW-1:0] regf_rd_s;
    logic [`WB_XLEN-1:0]   regf_rd_v;

    wb_stage_reg wb_stage_reg_inst (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_pc(in_pc),
        .in_rd_s(in_rd_s), .in_regf_we(in_regf_we), .in_mem_read(in_mem_read),
        .in_mem_write(in_mem_write), .in_load_op(in_load_op), .in_wb_sel(in_wb_sel),
        .in_alu_out(in_alu_out), .in_br_en(in_br_en), .in_u_imm(in_u_imm),
        .in_mem_addr(in_mem_addr), .dmem_resp(dmem_resp), .stall(stall), .done(done),
        .wb_pc(wb_pc), .wb_rd_s(wb_rd_s), .wb_regf_we(wb_regf_we),
        .wb_mem_write(wb_mem_write), .wb_load_op(wb_load_op), .wb_wb_sel(wb_wb_sel),
        .wb_alu_out(wb_alu_out), .wb_br_en(wb_br_en), .wb_u_imm(wb_u_imm),
        .wb_mem_addr(wb_mem_addr)
    );

    load_align load_align_inst (
        .wb_load_op(wb_load_op), .wb_mem_addr(wb_mem_addr),
        .dmem_rdata(dmem_rdata), .load_v(load_v)
    );

    result_select result_select_inst (
        .wb_wb_sel(wb_wb_sel), .wb_pc(wb_pc), .wb_alu_out(wb_alu_out),
        .wb_br_en(wb_br_en), .wb_u_imm(wb_u_imm), .sel_v(sel_v)
    );

    wb_commit wb_commit_inst (
        .clk(clk), .reset(reset), .done(done), .wb_wb_sel(wb_wb_sel),
        .wb_rd_s(wb_rd_s), .wb_regf_we(wb_regf_we), .wb_mem_write(wb_mem_write),
        .load_v(load_v), .sel_v(sel_v), .regf_we(regf_we), .regf_rd_s(regf_rd_s),
        .regf_rd_v(regf_rd_v), .retire_count(retire_count)
    );

    regfile regfile_inst (
        .clk(clk), .reset(reset), .regf_we(regf_we), .regf_rd_s(regf_rd_s),
        .regf_rd_v(regf_rd_v), .rs_s(rs_s), .rs_v(rs_v)
    );

endmodule

// ==== sim/wb_subsystem_tb.sv ====
`include "rv32i_wb_cfg.svh"

module wb_subsystem_tb;
    import rv32i_types::*;

    // Sum of the instructions issued below, used to size the watchdog
    localparam int NUM_INSTR = 51;

    logic                   clk;
    logic                   reset;
    logic                   in_valid;
    logic [`WB_XLEN-1:0]    in_pc;
    logic [`WB_REG_AW-1:0]  in_rd_s;
    logic                   in_regf_we;
    logic                   in_mem_read;
    logic                   in_mem_write;
    load_op_t               in_load_op;
    wb_sel_t                in_wb_sel;
    logic [`WB_XLEN-1:0]    in_alu_out;
    logic                   in_br_en;
    logic [`WB_XLEN-1:0]    in_u_imm;
    logic [`WB_XLEN-1:0]    in_mem_addr;
    logic                   dmem_resp;
    logic [`WB_XLEN-1:0]    dmem_rdata;
    logic                   stall;
    logic [`WB_REG_AW-1:0]  rs_s;
    logic [`WB_XLEN-1:0]    rs_v;
    logic [`WB_ORDER_W-1:0] retire_count;

    integer                 seed;
    int                     errors;
    int                     check_count;
    int                     checks_req;
    int                     checks_done;
    logic                   chk_all;
    logic [`WB_REG_AW-1:0]  chk_rd;
    logic [`WB_ORDER_W-1:0] expected_retired;
    logic [`WB_XLEN-1:0]    shadow [32];
    load_op_t               all_ops [5] = '{lb_mem, lbu_mem, lh_mem, lhu_mem, lw_mem};

    wb_subsystem wb_subsystem_inst (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_pc(in_pc),
        .in_rd_s(in_rd_s), .in_regf_we(in_regf_we), .in_mem_read(in_mem_read),
        .in_mem_write(in_mem_write), .in_load_op(in_load_op), .in_wb_sel(in_wb_sel),
        .in_alu_out(in_alu_out), .in_br_en(in_br_en), .in_u_imm(in_u_imm),
        .in_mem_addr(in_mem_addr), .dmem_resp(dmem_resp), .dmem_rdata(dmem_rdata),
        .stall(stall), .rs_s(rs_s), .rs_v(rs_v), .retire_count(retire_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Expected write-back value, taken straight from the RV32I load and select rules
    function automatic logic [31:0] ref_wb(input wb_sel_t sel, input load_op_t op,
                                           input logic [31:0] addr, input logic [31:0] rdata,
                                           input logic [31:0] alu, input logic br,
                                           input logic [31:0] uimm, input logic [31:0] pc);
        logic [31:0] shifted;
        shifted = rdata >> (8 * addr[1:0]);
        case (sel)
            alu_out_wb:  return alu;
            br_en_wb:    return {31'b0, br};
            u_imm_wb:    return uimm;
            pc_plus4_wb: return pc + 32'd4;
            load_wb: begin
                case (op)
                    lb_mem:  return {{24{shifted[7]}}, shifted[7:0]};
                    lbu_mem: return {24'b0, shifted[7:0]};
                    lh_mem:  return {{16{shifted[15]}}, shifted[15:0]};
                    lhu_mem: return {16'b0, shifted[15:0]};
                    default: return rdata;
                endcase
            end
            default:     return 32'b0;
        endcase
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        check_count = check_count + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic read_reg_check(input logic [4:0] r);
        @(posedge clk);
        #1;
        rs_s = r;
        @(negedge clk);
        check_value(64'(rs_v), 64'(shadow[r]), $sformatf("register x%0d", r));
    endtask

    task automatic request_check(input logic all_regs, input logic [4:0] rd);
        chk_all = all_regs;
        chk_rd = rd;
        checks_req = checks_req + 1;
        wait (checks_done == checks_req);
    endtask

    task automatic run_instr(input wb_sel_t sel, input load_op_t op, input logic [4:0] rd,
                             input logic we, input logic mem_write, input logic [1:0] off,
                             input int delay);
        logic [31:0] rnd;
        logic [31:0] addr;
        logic [31:0] rdata;
        logic [31:0] alu;
        logic [31:0] uimm;
        logic [31:0] pc;
        int          waited;
        rnd = $random(seed);
        addr = {rnd[31:2], off};
        rdata = $random(seed);
        alu = $random(seed);
        uimm = $random(seed);
        pc = $random(seed);
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        in_pc = pc;
        in_rd_s = rd;
        in_regf_we = we;
        in_mem_read = (sel == load_wb);
        in_mem_write = mem_write;
        in_load_op = op;
        in_wb_sel = sel;
        in_alu_out = alu;
        in_br_en = rnd[1];
        in_u_imm = {uimm[31:12], 12'b0};
        in_mem_addr = addr;
        dmem_resp = 1'b0;
        dmem_rdata = $random(seed);
        @(posedge clk);
        #1;
        // Accepted, so new upstream values must not reach the held entry
        in_valid = 1'b0;
        in_alu_out = $random(seed);
        in_mem_addr = $random(seed);
        if (sel == load_wb) begin
            for (waited = 0; waited < delay; waited++) begin
                @(negedge clk);
                check_value(64'(stall), 64'd1, "stall while load waits");
                check_value(retire_count, expected_retired, "retire_count before response");
                @(posedge clk);
                #1;
            end
            dmem_rdata = rdata;
            dmem_resp = 1'b1;
        end else begin
            // A response with no load held has to be ignored
            dmem_resp = rnd[0];
        end
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        dmem_resp = 1'b0;
        dmem_rdata = $random(seed);
        expected_retired = expected_retired + 64'd1;
        if (we && !mem_write && rd != 5'd0) begin
            shadow[rd] = ref_wb(sel, op, addr, rdata, alu, rnd[1], {uimm[31:12], 12'b0}, pc);
        end
        request_check(1'b0, rd);
    endtask

    task automatic load_instr(input load_op_t op, input logic [1:0] off, input int delay);
        logic [31:0] rnd;
        rnd = $random(seed);
        run_instr(load_wb, op, (rnd[4:0] == 5'd0) ? 5'd1 : rnd[4:0], 1'b1, 1'b0, off, delay);
    endtask

    task automatic select_instr(input wb_sel_t sel);
        logic [31:0] rnd;
        rnd = $random(seed);
        run_instr(sel, lw_mem, (rnd[4:0] == 5'd0) ? 5'd1 : rnd[4:0], 1'b1, 1'b0, 2'd0, 0);
    endtask

    initial begin
        rs_s = '0;
        forever begin
            wait (checks_req != checks_done);
            if (chk_all) begin
                for (int r = 0; r < 32; r++) begin
                    read_reg_check(r[4:0]);
                end
            end else begin
                read_reg_check(chk_rd);
                read_reg_check(5'd0);
            end
            check_value(retire_count, expected_retired, "retire_count");
            checks_done = checks_done + 1;
        end
    end

    initial begin
        #((NUM_INSTR * 20 + 300) * 10);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        load_op_t    op;
        logic [1:0]  off;
        int          delay;
        seed = 32'h4e93;
        errors = 0;
        check_count = 0;
        checks_req = 0;
        checks_done = 0;
        chk_all = 1'b0;
        chk_rd = '0;
        expected_retired = '0;
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end
        reset = 1'b1;
        in_valid = 1'b0;
        in_pc = '0;
        in_rd_s = '0;
        in_regf_we = 1'b0;
        in_mem_read = 1'b0;
        in_mem_write = 1'b0;
        in_load_op = lb_mem;
        in_wb_sel = alu_out_wb;
        in_alu_out = '0;
        in_br_en = 1'b0;
        in_u_imm = '0;
        in_mem_addr = '0;
        dmem_resp = 1'b0;
        dmem_rdata = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value(64'(stall), 64'd0, "stall after reset");
        request_check(1'b1, 5'd0);

        // Every load opcode at every legal offset
        for (int round = 0; round < 2; round++) begin
            for (int o = 0; o < 4; o++) begin
                load_instr(lb_mem, o[1:0], 0);
                load_instr(lbu_mem, o[1:0], 0);
                if (o[0] == 1'b0) begin
                    load_instr(lh_mem, o[1:0], 0);
                    load_instr(lhu_mem, o[1:0], 0);
                end
                if (o == 0) begin
                    load_instr(lw_mem, 2'd0, 0);
                end
            end
        end

        for (int round = 0; round < 3; round++) begin
            select_instr(alu_out_wb);
            select_instr(br_en_wb);
            select_instr(u_imm_wb);
            select_instr(pc_plus4_wb);
        end

        // None of these may change the register file
        run_instr(alu_out_wb, lw_mem, 5'd0, 1'b1, 1'b0, 2'd0, 0);
        run_instr(alu_out_wb, lw_mem, 5'd7, 1'b0, 1'b0, 2'd0, 0);
        run_instr(alu_out_wb, lw_mem, 5'd9, 1'b1, 1'b1, 2'd0, 0);
        run_instr(u_imm_wb, lw_mem, 5'd12, 1'b0, 1'b1, 2'd0, 0);

        // A response with no load held must not release the next load early
        @(posedge clk);
        #1;
        dmem_resp = 1'b1;
        dmem_rdata = $random(seed);
        @(posedge clk);
        #1;
        dmem_resp = 1'b0;
        run_instr(load_wb, lw_mem, 5'd0, 1'b1, 1'b0, 2'd0, 2);

        for (int n = 0; n < 8; n++) begin
            rnd = $random(seed);
            op = all_ops[rnd % 32'd5];
            off = rnd[9:8];
            if (op == lh_mem || op == lhu_mem) begin
                off[0] = 1'b0;
            end
            if (op == lw_mem) begin
                off = 2'd0;
            end
            delay = rnd[23:16] % 6;
            load_instr(op, off, delay);
        end

        // Sweep every register
        request_check(1'b1, 5'd0);

        $display("Checks: %0d, errors: %0d, retired: %0d", check_count, errors, retire_count);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+design
design/rv32i_types.sv
design/wb_stage_reg.sv
design/load_align.sv
design/result_select.sv
design/wb_commit.sv
design/regfile.sv
design/wb_subsystem.sv
sim/wb_subsystem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the write-back testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f \
        --top-module wb_subsystem_tb -o wb_subsystem_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/wb_subsystem_sim); then
    echo "$output"
    echo "Simulation exited with an error status"
    exit 1
fi

echo "$output"

if grep -qxF '** PASS **' <<< "$output"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
